// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := i2c_slave_tb
FILELIST  := i2c_slave_top.f
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: hdl/i2c_line_sampler.sv
`timescale 1ns/1ps

module i2c_line_sampler
(
    input  logic                       CLK,
    input  logic                       RST_n,
    input  logic                       scl,
    input  logic                       sda,
    output i2c_slave_pkg::bus_events_t events
);

    // bit 1 carries scl, bit 0 carries sda
    logic [1:0] meta;  // first synchronizer stage
    logic [1:0] sync;  // second synchronizer stage
    logic [1:0] hist;  // previous synchronized level

    logic scl_now;
    logic scl_old;
    logic sda_now;
    logic sda_old;

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            meta <= '1;  // idle bus reads high
            sync <= '1;
            hist <= '1;
        end
        else
        begin
            meta <= {scl, sda};
            sync <= meta;
            hist <= sync;
        end
    end

    assign scl_now = sync[1];
    assign scl_old = hist[1];
    assign sda_now = sync[0];
    assign sda_old = hist[0];

    assign events.scl_rise = scl_now & ~scl_old;
    assign events.scl_fall = ~scl_now & scl_old;

    // sda edges only count as conditions while scl stays high
    assign events.start = scl_now & scl_old & sda_old & ~sda_now;
    assign events.stop  = scl_now & scl_old & ~sda_old & sda_now;

    assign events.sda = sda_now;

endmodule

// File: hdl/i2c_reg_bank.sv
`timescale 1ns/1ps

module i2c_reg_bank
(
    input  logic                       CLK,
    input  logic                       RST_n,
    input  i2c_slave_pkg::reg_access_t access,
    output i2c_slave_pkg::byte_t       rdata
);

    import i2c_slave_pkg::*;

    byte_t regs [reg_count];

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
        end
        else if (access.wr_en)
        begin
            regs[access.ptr] <= access.wdata;
        end
    end

    // read port follows ptr in the same cycle
    assign rdata = regs[access.ptr];

endmodule

// File: hdl/i2c_slave_fsm.sv
`timescale 1ns/1ps

module i2c_slave_fsm
(
    input  logic                       CLK,
    input  logic                       RST_n,
    input  i2c_slave_pkg::bus_events_t events,
    input  i2c_slave_pkg::byte_t       rdata,
    output i2c_slave_pkg::reg_access_t access,
    output logic                       sda_oe,
    output logic                       busy
);

    import i2c_slave_pkg::*;

    slave_state_t state;
    byte_t        rx_shift;   // bits from the master, msb first
    byte_t        tx_shift;   // remaining bits of the byte being sent
    bit_cnt_t     bit_cnt;
    reg_ptr_t     ptr;
    logic         rw;         // latched r/w bit of the address byte
    logic         byte_full;  // all eight bits clocked, ack slot next
    logic         wr_en;

    logic in_byte;
    logic last_rise;
    logic addr_match;
    logic tx_load;
    logic tx_step;

    assign in_byte = (state == st_addr) || (state == st_ptr) ||
                     (state == st_write) || (state == st_read);

    assign last_rise  = in_byte && events.scl_rise && (bit_cnt == '0);
    assign addr_match = (rx_shift[byte_width-1:1] == i2c_slave_addr);

    // a new read byte starts after the address ack or a master ack
    assign tx_load = events.scl_fall &&
                     (((state == st_addr_ack) && rw) || (state == st_read_ack));
    assign tx_step = events.scl_fall && (state == st_read) && !byte_full;

    always_ff @(posedge CLK)
    begin
        if (events.scl_rise)
            rx_shift <= {rx_shift[byte_width-2:0], events.sda};

        if (tx_load)
            tx_shift <= {rdata[byte_width-2:0], 1'b0};  // msb goes out now
        else if (tx_step)
            tx_shift <= {tx_shift[byte_width-2:0], 1'b0};
    end

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            state     <= st_idle;
            bit_cnt   <= '1;
            ptr       <= '0;
            rw        <= 1'b0;
            byte_full <= 1'b0;
            wr_en     <= 1'b0;
            sda_oe    <= 1'b0;
            busy      <= 1'b0;
        end
        else
        begin
            wr_en <= 1'b0;  // single-cycle strobe

            if (events.stop)
            begin
                state     <= st_idle;
                byte_full <= 1'b0;
                sda_oe    <= 1'b0;
                busy      <= 1'b0;
            end
            else if (events.start)  // also a repeated start
            begin
                state     <= st_addr;
                bit_cnt   <= '1;
                byte_full <= 1'b0;
                sda_oe    <= 1'b0;
                busy      <= 1'b1;
            end
            else
            begin
                if (in_byte && events.scl_rise)
                begin
                    if (bit_cnt == '0)
                        byte_full <= 1'b1;
                    else
                        bit_cnt <= bit_cnt - 1'b1;
                end

                case (state)
                    st_addr:
                    begin
                        if (events.scl_fall && byte_full)
                        begin
                            byte_full <= 1'b0;
                            if (addr_match)
                            begin
                                rw     <= rx_shift[0];
                                sda_oe <= 1'b1;  // ack
                                state  <= st_addr_ack;
                            end
                            else
                                state <= st_idle;  // not ours, busy held until stop
                        end
                    end
                    st_addr_ack:
                    begin
                        if (events.scl_fall)
                        begin
                            bit_cnt <= '1;
                            if (rw)
                            begin
                                sda_oe <= ~rdata[byte_width-1];
                                state  <= st_read;
                            end
                            else
                            begin
                                sda_oe <= 1'b0;
                                state  <= st_ptr;
                            end
                        end
                    end
                    st_ptr:
                    begin
                        if (events.scl_fall && byte_full)
                        begin
                            byte_full <= 1'b0;
                            ptr       <= rx_shift[ptr_width-1:0];
                            sda_oe    <= 1'b1;
                            state     <= st_ptr_ack;
                        end
                    end
                    st_ptr_ack, st_write_ack:
                    begin
                        if (events.scl_fall)
                        begin
                            sda_oe  <= 1'b0;
                            bit_cnt <= '1;
                            state   <= st_write;
                        end
                    end
                    st_write:
                    begin
                        if (last_rise)
                            wr_en <= 1'b1;  // rx_shift holds the byte next cycle
                        if (events.scl_fall && byte_full)
                        begin
                            byte_full <= 1'b0;
                            ptr       <= ptr + 1'b1;
                            sda_oe    <= 1'b1;
                            state     <= st_write_ack;
                        end
                    end
                    st_read:
                    begin
                        if (events.scl_fall)
                        begin
                            if (byte_full)
                            begin
                                byte_full <= 1'b0;
                                sda_oe    <= 1'b0;  // master drives ack bit
                                state     <= st_read_ack;
                            end
                            else
                                sda_oe <= ~tx_shift[byte_width-1];
                        end
                    end
                    st_read_ack:
                    begin
                        if (events.scl_rise)
                        begin
                            if (events.sda)
                                state <= st_idle;  // nack ends the read
                            else
                                ptr <= ptr + 1'b1;
                        end
                        if (events.scl_fall)
                        begin
                            bit_cnt <= '1;
                            sda_oe  <= ~rdata[byte_width-1];  // rdata already at new ptr
                            state   <= st_read;
                        end
                    end
                    default:
                        state <= st_idle;
                endcase
            end
        end
    end

    assign access.wr_en = wr_en;
    assign access.ptr   = ptr;
    assign access.wdata = rx_shift;

endmodule

// File: hdl/i2c_slave_pkg.sv
package i2c_slave_pkg;

    localparam int byte_width    = 8;
    localparam int addr_width    = 7;
    localparam int reg_count     = 16;
    localparam int ptr_width     = $clog2(reg_count);
    localparam int bit_cnt_width = $clog2(byte_width);

    typedef logic [byte_width-1:0]    byte_t;       // data, address or pointer byte
    typedef logic [addr_width-1:0]    slave_addr_t; // 7-bit device address
    typedef logic [ptr_width-1:0]     reg_ptr_t;    // wraps at reg_count
    typedef logic [bit_cnt_width-1:0] bit_cnt_t;    // bits left in the byte

    localparam slave_addr_t i2c_slave_addr = 7'h42;

    typedef enum logic [3:0]
    {
        st_idle,
        st_addr,      // address byte + r/w bit
        st_addr_ack,
        st_ptr,       // register pointer byte
        st_ptr_ack,
        st_write,
        st_write_ack,
        st_read,
        st_read_ack   // master ack / nack
    } slave_state_t;

    // one CLK cycle's view of the bus
    typedef struct packed
    {
        logic scl_rise;
        logic scl_fall;
        logic start;
        logic stop;
        logic sda;      // synchronized level
    } bus_events_t;

    typedef struct packed
    {
        logic     wr_en;
        reg_ptr_t ptr;
        byte_t    wdata;
    } reg_access_t;

endpackage

// File: hdl/i2c_slave_top.sv
`timescale 1ns/1ps

module i2c_slave_top
(
    input  logic CLK,
    input  logic RST_n,
    input  logic scl,
    input  logic sda,
    output logic sda_oe,  // high pulls sda low
    output logic busy
);

    import i2c_slave_pkg::*;

    bus_events_t events;
    reg_access_t access;
    byte_t       rdata;

    i2c_line_sampler i2c_line_sampler_i
    (
        .CLK    (CLK),
        .RST_n  (RST_n),
        .scl    (scl),
        .sda    (sda),
        .events (events)
    );

    i2c_slave_fsm i2c_slave_fsm_i
    (
        .CLK    (CLK),
        .RST_n  (RST_n),
        .events (events),
        .rdata  (rdata),
        .access (access),
        .sda_oe (sda_oe),
        .busy   (busy)
    );

    i2c_reg_bank i2c_reg_bank_i
    (
        .CLK    (CLK),
        .RST_n  (RST_n),
        .access (access),
        .rdata  (rdata)
    );

endmodule

// File: i2c_slave_top.f
hdl/i2c_slave_pkg.sv
hdl/i2c_line_sampler.sv
hdl/i2c_slave_fsm.sv
hdl/i2c_reg_bank.sv
hdl/i2c_slave_top.sv
+incdir+tests
tests/tb_clock_gen.sv
tests/i2c_slave_asserts.sv
tests/i2c_slave_tb.sv

// File: tests/i2c_slave_asserts.sv
`timescale 1ns/1ps

module i2c_slave_asserts
(
    input logic                       CLK,
    input logic                       RST_n,
    input i2c_slave_pkg::bus_events_t events,
    input i2c_slave_pkg::reg_access_t access,
    input logic                       sda_oe,
    input logic                       busy
);

    int violations = 0;  // summed up by the testbench

    oe_needs_busy: assert property (@(posedge CLK) disable iff (!RST_n) sda_oe |-> busy)
    else
    begin
        violations++;
        $error("sda_oe high while the slave is not busy");
    end

    stop_clears_busy: assert property (@(posedge CLK) disable iff (!RST_n)
                                       events.stop |=> !busy)
    else
    begin
        violations++;
        $error("busy still high the cycle after a stop pulse");
    end

    write_needs_busy: assert property (@(posedge CLK) disable iff (!RST_n)
                                       access.wr_en |-> busy)
    else
    begin
        violations++;
        $error("register write strobe outside a transfer");
    end

endmodule

bind i2c_slave_fsm i2c_slave_asserts i2c_slave_asserts_i
(
    .CLK    (CLK),
    .RST_n  (RST_n),
    .events (events),
    .access (access),
    .sda_oe (sda_oe),
    .busy   (busy)
);

// File: tests/i2c_master_tasks.svh
// bit-level I2C master, every pin change on a falling CLK edge

task automatic idle_cycles(input int n);
    repeat (n) @(negedge CLK);
endtask

// also serves as repeated start, entered with scl low
task automatic start_condition();
    sda_drv = 1'b1;
    idle_cycles(10);
    scl_drv = 1'b1;
    idle_cycles(20);
    sda_drv = 1'b0;  // sda falls while scl high
    idle_cycles(20);
    scl_drv = 1'b0;
    idle_cycles(10);
endtask

task automatic stop_condition();
    sda_drv = 1'b0;
    idle_cycles(10);
    scl_drv = 1'b1;
    idle_cycles(20);
    sda_drv = 1'b1;  // sda rises while scl high
    idle_cycles(20);
    after_nack = 1'b0;
    check(busy === 1'b0, "busy still high after STOP");
endtask

// one scl pulse, sda changes mid-low and is sampled mid-high
task automatic clock_bit(input logic b, output logic s);
    check(busy === 1'b1, "busy low while SCL is held low inside a transfer");
    sda_drv = b;
    idle_cycles(10);
    scl_drv = 1'b1;
    idle_cycles(10);
    s = sda_line;
    idle_cycles(10);
    scl_drv = 1'b0;
    idle_cycles(10);
endtask

task automatic write_byte(input byte_t b, output logic ack);
    logic s;
    for (int i = byte_width - 1; i >= 0; i--)
        clock_bit(b[i], s);
    clock_bit(1'b1, s);  // released for the slave ack
    ack = ~s;
endtask

task automatic read_byte(input logic ack, output byte_t b);
    logic s;
    for (int i = byte_width - 1; i >= 0; i--)
    begin
        clock_bit(1'b1, s);
        b[i] = s;
    end
    if (!ack)
        after_nack = 1'b1;  // slave keeps sda released from here on
    clock_bit(~ack, s);
endtask

// File: tests/i2c_slave_tb.sv
`timescale 1ns/1ps

module i2c_slave_tb;

    import i2c_slave_pkg::*;

    typedef enum logic {kind_write, kind_read} xfer_kind_t;

    // one entry is one transaction
    typedef struct packed
    {
        xfer_kind_t  kind;
        slave_addr_t addr;
        reg_ptr_t    ptr;
        logic [2:0]  len;   // 1 to 4 data bytes
        byte_t [3:0] data;
    } xfer_t;

    logic CLK;
    logic RST_n;
    logic scl_drv;
    logic sda_drv;
    logic scl_line;
    logic sda_line;
    logic sda_oe;
    logic busy;
    logic after_nack;

    xfer_t       xfers [6];
    byte_t       model [reg_count];
    logic [31:0] rng_state;
    int          err_count = 0;
    int          check_count = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    assign scl_line = scl_drv;
    assign sda_line = sda_drv & ~sda_oe;  // open-drain wired-and

    tb_clock_gen tb_clock_gen_i
    (
        .CLK   (CLK),
        .RST_n (RST_n)
    );

    i2c_slave_top i2c_slave_top_i
    (
        .CLK    (CLK),
        .RST_n  (RST_n),
        .scl    (scl_line),
        .sda    (sda_line),
        .sda_oe (sda_oe),
        .busy   (busy)
    );

    task automatic log_error(input string msg);
        err_count++;
        $display("** Error at %0d ns: %s", $time, msg);
    endtask

    task automatic check(input logic ok, input string msg);
        check_count++;
        assert (ok) else log_error(msg);
    endtask

    `include "i2c_master_tasks.svh"

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic build_table();
        xfers[0] = '{kind: kind_write, addr: i2c_slave_addr, ptr: 4'd3,  len: 3'd3, data: '0};
        xfers[1] = '{kind: kind_read,  addr: i2c_slave_addr, ptr: 4'd3,  len: 3'd3, data: '0};
        xfers[2] = '{kind: kind_write, addr: i2c_slave_addr, ptr: 4'd14, len: 3'd4, data: '0};
        xfers[3] = '{kind: kind_read,  addr: i2c_slave_addr, ptr: 4'd14, len: 3'd4, data: '0};
        xfers[4] = '{kind: kind_write, addr: 7'h17,          ptr: 4'd3,  len: 3'd2, data: '0};
        xfers[5] = '{kind: kind_read,  addr: i2c_slave_addr, ptr: 4'd2,  len: 3'd4, data: '0};
        foreach (xfers[n])
            for (int i = 0; i < 4; i++)
                if (xfers[n].kind == kind_write)
                begin
                    rng_state = xorshift32(rng_state);
                    xfers[n].data[i] = rng_state[7:0];
                end
    endtask

    // nine bits per byte, 40 cycles per bit
    function automatic int total_bits();
        int bits;
        bits = 0;
        foreach (xfers[n])
            bits += 9 * (int'(xfers[n].len) + ((xfers[n].kind == kind_read) ? 3 : 2));
        return bits;
    endfunction

    // a foreign address must not change the model or draw any ack
    task automatic run_write(input xfer_t x);
        logic     ack;
        logic     ours;
        reg_ptr_t idx;
        int       len;
        ours = (x.addr == i2c_slave_addr);
        len  = int'(x.len);
        start_condition();
        write_byte({x.addr, 1'b0}, ack);
        check(ack == ours, $sformatf("address 0x%02h got ack %0b", x.addr, ack));
        write_byte({4'h0, x.ptr}, ack);
        check(ack == ours, $sformatf("pointer byte got ack %0b", ack));
        for (int i = 0; i < len; i++)
        begin
            write_byte(x.data[i], ack);
            check(ack == ours, $sformatf("data byte %0d got ack %0b", i, ack));
            idx = x.ptr + reg_ptr_t'(i);
            if (ours)
                model[idx] = x.data[i];
        end
        stop_condition();
    endtask

    task automatic run_read(input xfer_t x);
        logic     ack;
        byte_t    got;
        reg_ptr_t idx;
        int       len;
        len = int'(x.len);
        start_condition();
        write_byte({x.addr, 1'b0}, ack);
        check(ack, "no ack for the address byte before the pointer");
        write_byte({4'h0, x.ptr}, ack);
        check(ack, "no ack for the pointer byte");
        start_condition();  // repeated start
        write_byte({x.addr, 1'b1}, ack);
        check(ack, "no ack for the read address byte");
        for (int i = 0; i < len; i++)
        begin
            idx = x.ptr + reg_ptr_t'(i);
            read_byte(i < len - 1, got);  // nack on the last byte
            check(got === model[idx], $sformatf("register %0d read 0x%02h, expected 0x%02h",
                                                idx, got, model[idx]));
        end
        stop_condition();
    endtask

    // after_nack only moves on falling edges
    always @(posedge CLK)
    begin
        if (after_nack)
            check(sda_oe === 1'b0, "slave drives SDA after the master's NACK");
    end

    always @(posedge CLK)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    initial
    begin
        int    errs_before;
        string what;
        scl_drv    = 1'b1;
        sda_drv    = 1'b1;
        after_nack = 1'b0;
        rng_state  = 32'h3a88_f67b;
        foreach (model[i])
            model[i] = '0;
        build_table();
        cycle_limit = total_bits() * 40 + $size(xfers) * 300 + 1000;

        wait (RST_n === 1'b1);
        idle_cycles(10);
        errs_before = err_count;
        check(busy === 1'b0, "busy high after reset");
        check(sda_oe === 1'b0, "sda_oe high after reset");
        $display("test 0 idle after reset: %s", (err_count == errs_before) ? "ok" : "FAILED");

        foreach (xfers[n])
        begin
            errs_before = err_count;
            what = $sformatf("%s addr 0x%02h ptr %0d len %0d",
                             (xfers[n].kind == kind_write) ? "write" : "read",
                             xfers[n].addr, xfers[n].ptr, xfers[n].len);
            if (xfers[n].kind == kind_write)
                run_write(xfers[n]);
            else
                run_read(xfers[n]);
            $display("test %0d %s: %s", n + 1, what, (err_count == errs_before) ? "ok" : "FAILED");
        end

        check(i2c_slave_top_i.i2c_slave_fsm_i.i2c_slave_asserts_i.violations == 0,
              "bound protocol assertions reported violations");
        $display("summary: %0d tests, %0d checks, %0d errors",
                 $size(xfers) + 1, check_count, err_count);
        if (err_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic CLK,
    output logic RST_n
);

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;  // 10 ns period
    end

    initial
    begin
        RST_n = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RST_n = 1'b1;  // released between edges
    end

endmodule
